//--- include/shell_macros.svh
`ifndef SHELL_MACROS_SVH
`define SHELL_MACROS_SVH

// bus widths
`define SHELL_DATA_W   32
`define SHELL_ADDR_W   32
`define WIN_ADDR_W     30
`define DIRECT_ADDR_W  28

// profiler, one bit per 8 MB region of DRAM
`define PROF_W         128
`define PROF_LSB       23

// core physical DRAM starts here
`define CORE_DRAM_BASE 32'h8000_0000

// host register map
`define CSR_IDX_W      3
`define CSR_RESET      3'd0
`define CSR_BITBANG    3'd1
`define CSR_DRAM_BASE  3'd2
`define CSR_BB_BUSY    3'd3
`define CSR_PROF0      3'd4

`endif

//--- source/shell_bus_pkg.sv
`include "shell_macros.svh"

package shell_bus_pkg;

   // host and core data word
   typedef logic [`SHELL_DATA_W-1:0] data_t;

   // core physical address, also the DRAM address
   typedef logic [`SHELL_ADDR_W-1:0] addr_t;

   // windowed host port, top two bits already dropped by the host
   typedef logic [`WIN_ADDR_W-1:0] win_addr_t;

   // direct host port
   typedef logic [`DIRECT_ADDR_W-1:0] direct_addr_t;

endpackage

//--- source/shell_csr_pkg.sv
`include "shell_macros.svh"

package shell_csr_pkg;

   // host register index
   typedef logic [`CSR_IDX_W-1:0] csr_idx_t;

   // region touch bits
   typedef logic [`PROF_W-1:0] prof_t;

   // bit-bang sequence: present data, raise clock, drop clock
   typedef enum logic [1:0] {
      BB_IDLE,
      BB_DATA,
      BB_CLK_HI,
      BB_CLK_LO
   } bb_state_e;

endpackage

//--- source/host_csr_regs.sv
`include "shell_macros.svh"

module host_csr_regs
   import shell_bus_pkg::*;
   import shell_csr_pkg::*;
(
   input  logic     aclk_i,
   input  logic     arst_n_i,
   input  logic     csr_we_i,
   input  csr_idx_t csr_widx_i,
   input  data_t    csr_wdata_i,
   input  csr_idx_t csr_ridx_i,
   input  prof_t    prof_i,
   input  logic     bb_busy_i,
   output data_t    csr_rdata_o,
   output logic     sys_reset_n_o,
   output logic     bb_v_o,
   output logic     bb_bit_o,
   output addr_t    dram_base_o
);

   data_t      reset_r;
   data_t      bitbang_r;
   addr_t      dram_base_r;
   logic       bb_v_r;
   data_t      rdata_r;
   data_t      rdata_mux;
   logic [1:0] prof_word;

   ////////////////////////////////////////
   // host writes
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         reset_r     <= '0;
         bitbang_r   <= '0;
         dram_base_r <= '0;
         bb_v_r      <= 1'b0;
      end else begin
         // strobe lines up with the new bit-bang value
         bb_v_r <= csr_we_i && (csr_widx_i == `CSR_BITBANG);
         if (csr_we_i) begin
            case (csr_widx_i)
               `CSR_RESET:     reset_r     <= csr_wdata_i;
               `CSR_BITBANG:   bitbang_r   <= csr_wdata_i;
               `CSR_DRAM_BASE: dram_base_r <= csr_wdata_i;
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // readback, registered
   // indices 4 to 7 map to profiler words 0 to 3
   assign prof_word = 2'(csr_ridx_i - `CSR_PROF0);

   always_comb begin
      case (csr_ridx_i)
         `CSR_RESET:     rdata_mux = reset_r;
         `CSR_BITBANG:   rdata_mux = bitbang_r;
         `CSR_DRAM_BASE: rdata_mux = dram_base_r;
         `CSR_BB_BUSY:   rdata_mux = {{(`SHELL_DATA_W-1){1'b0}}, bb_busy_i};
         default:        rdata_mux = prof_i[prof_word*`SHELL_DATA_W +: `SHELL_DATA_W];
      endcase
   end

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rdata_r <= '0;
      end else begin
         rdata_r <= rdata_mux;
      end
   end

   assign csr_rdata_o   = rdata_r;
   // core reset is active low, held in bit 0
   assign sys_reset_n_o = reset_r[0];
   assign bb_v_o        = bb_v_r;
   assign bb_bit_o      = bitbang_r[0];
   assign dram_base_o   = dram_base_r;

endmodule

//--- source/host_port_arbiter.sv
`include "shell_macros.svh"

module host_port_arbiter
   import shell_bus_pkg::*;
(
   input  logic         aclk_i,
   input  logic         arst_n_i,
   input  logic         w_req_i,
   input  logic         w_we_i,
   input  win_addr_t    w_addr_i,
   input  data_t        w_wdata_i,
   output logic         w_gnt_o,
   input  logic         d_req_i,
   input  logic         d_we_i,
   input  direct_addr_t d_addr_i,
   input  data_t        d_wdata_i,
   output logic         d_gnt_o,
   input  logic         core_ready_i,
   output logic         core_v_o,
   output logic         core_we_o,
   output addr_t        core_addr_o,
   output data_t        core_wdata_o
);

   addr_t w_addr_xlat;
   addr_t d_addr_xlat;
   logic  core_free;
   logic  w_gnt;
   logic  d_gnt;
   logic  prio_d_r;
   logic  core_v_r;
   logic  core_we_r;
   addr_t core_addr_r;
   data_t core_wdata_r;

   ////////////////////////////////////////
   // address translation
   // window 0x0xxx_xxxx goes to core DRAM at 0x8xxx_xxxx,
   // window 0x2xxx_xxxx goes to core local space at 0x0xxx_xxxx
   assign w_addr_xlat = {~w_addr_i[`WIN_ADDR_W-1], 3'b000, w_addr_i[27:0]};
   assign d_addr_xlat = {{(`SHELL_ADDR_W-`DIRECT_ADDR_W){1'b0}}, d_addr_i};

   ////////////////////////////////////////
   // round-robin grant
   // output register is free when empty or draining this cycle
   assign core_free = !core_v_r || core_ready_i;

   // prio_d_r is set when w won last, so d wins the next tie
   assign w_gnt = core_free && w_req_i && (!d_req_i || !prio_d_r);
   assign d_gnt = core_free && d_req_i && (!w_req_i || prio_d_r);

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         core_v_r <= 1'b0;
         prio_d_r <= 1'b0;
      end else begin
         if (w_gnt || d_gnt) begin
            core_v_r <= 1'b1;
            prio_d_r <= w_gnt;
         end else if (core_ready_i) begin
            core_v_r <= 1'b0;
         end
      end
   end

   // request fields, loaded on grant and held until accepted
   always_ff @(posedge aclk_i) begin
      if (w_gnt) begin
         core_we_r    <= w_we_i;
         core_addr_r  <= w_addr_xlat;
         core_wdata_r <= w_wdata_i;
      end else if (d_gnt) begin
         core_we_r    <= d_we_i;
         core_addr_r  <= d_addr_xlat;
         core_wdata_r <= d_wdata_i;
      end
   end

   assign w_gnt_o      = w_gnt;
   assign d_gnt_o      = d_gnt;
   assign core_v_o     = core_v_r;
   assign core_we_o    = core_we_r;
   assign core_addr_o  = core_addr_r;
   assign core_wdata_o = core_wdata_r;

endmodule

//--- source/dram_addr_map.sv
`include "shell_macros.svh"

module dram_addr_map
   import shell_bus_pkg::*;
   import shell_csr_pkg::*;
(
   input  logic  aclk_i,
   input  logic  arst_n_i,
   input  logic  sys_reset_n_i,
   input  addr_t dram_base_i,
   input  logic  dram_v_i,
   input  addr_t dram_addr_i,
   output logic  dram_v_o,
   output addr_t dram_addr_o,
   output prof_t prof_o
);

   logic                        dram_v_r;
   addr_t                       dram_addr_r;
   prof_t                       prof_r;
   logic [$clog2(`PROF_W)-1:0]  region;

   ////////////////////////////////////////
   // rebasing, one stage, no stall
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dram_v_r <= 1'b0;
      end else begin
         dram_v_r <= dram_v_i;
      end
   end

   // strip the core DRAM base, then add the host-allocated base
   always_ff @(posedge aclk_i) begin
      dram_addr_r <= (dram_addr_i ^ `CORE_DRAM_BASE) + dram_base_i;
   end

   ////////////////////////////////////////
   // region touch profiler
   assign region = dram_addr_i[`PROF_LSB +: $clog2(`PROF_W)];

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         prof_r <= '0;
      end else if (!sys_reset_n_i) begin
         prof_r <= '0;
      end else if (dram_v_i) begin
         prof_r[region] <= 1'b1;
      end
   end

   assign dram_v_o    = dram_v_r;
   assign dram_addr_o = dram_addr_r;
   assign prof_o      = prof_r;

endmodule

//--- source/tag_bitbang.sv
module tag_bitbang
   import shell_csr_pkg::*;
(
   input  logic aclk_i,
   input  logic arst_n_i,
   input  logic bb_v_i,
   input  logic bb_bit_i,
   output logic bb_busy_o,
   output logic tag_clk_o,
   output logic tag_data_o
);

   bb_state_e state_r;
   logic      tag_clk_r;
   logic      tag_data_r;

   // tag clock comes straight from a flop, no decode glitches
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_r    <= BB_IDLE;
         tag_clk_r  <= 1'b0;
         tag_data_r <= 1'b0;
      end else begin
         case (state_r)
            BB_IDLE: begin
               // strobes outside idle are lost
               if (bb_v_i) begin
                  tag_data_r <= bb_bit_i;
                  state_r    <= BB_DATA;
               end
            end
            BB_DATA: begin
               tag_clk_r <= 1'b1;
               state_r   <= BB_CLK_HI;
            end
            BB_CLK_HI: begin
               tag_clk_r <= 1'b0;
               state_r   <= BB_CLK_LO;
            end
            default: begin
               state_r <= BB_IDLE;
            end
         endcase
      end
   end

   assign bb_busy_o  = (state_r != BB_IDLE);
   assign tag_clk_o  = tag_clk_r;
   assign tag_data_o = tag_data_r;

endmodule

//--- source/zynq_shell_top.sv
module zynq_shell_top
   import shell_bus_pkg::*;
   import shell_csr_pkg::*;
(
   input  logic         aclk_i,
   input  logic         arst_n_i,
   // host register port
   input  logic         csr_we_i,
   input  csr_idx_t     csr_widx_i,
   input  data_t        csr_wdata_i,
   input  csr_idx_t     csr_ridx_i,
   output data_t        csr_rdata_o,
   // windowed host port
   input  logic         w_req_i,
   input  logic         w_we_i,
   input  win_addr_t    w_addr_i,
   input  data_t        w_wdata_i,
   output logic         w_gnt_o,
   // direct host port
   input  logic         d_req_i,
   input  logic         d_we_i,
   input  direct_addr_t d_addr_i,
   input  data_t        d_wdata_i,
   output logic         d_gnt_o,
   // core request bus
   input  logic         core_ready_i,
   output logic         core_v_o,
   output logic         core_we_o,
   output addr_t        core_addr_o,
   output data_t        core_wdata_o,
   // core DRAM side
   input  logic         dram_v_i,
   input  addr_t        dram_addr_i,
   output logic         dram_v_o,
   output addr_t        dram_addr_o,
   output logic         sys_reset_n_o,
   output logic         tag_clk_o,
   output logic         tag_data_o
);

   prof_t prof;
   addr_t dram_base;
   logic  bb_v;
   logic  bb_bit;
   logic  bb_busy;

   host_csr_regs i_csr (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i), .csr_we_i(csr_we_i), .csr_widx_i(csr_widx_i),
      .csr_wdata_i(csr_wdata_i), .csr_ridx_i(csr_ridx_i), .prof_i(prof),
      .bb_busy_i(bb_busy), .csr_rdata_o(csr_rdata_o), .sys_reset_n_o(sys_reset_n_o),
      .bb_v_o(bb_v), .bb_bit_o(bb_bit), .dram_base_o(dram_base)
   );

   host_port_arbiter i_arb (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i),
      .w_req_i(w_req_i), .w_we_i(w_we_i), .w_addr_i(w_addr_i), .w_wdata_i(w_wdata_i),
      .w_gnt_o(w_gnt_o),
      .d_req_i(d_req_i), .d_we_i(d_we_i), .d_addr_i(d_addr_i), .d_wdata_i(d_wdata_i),
      .d_gnt_o(d_gnt_o),
      .core_ready_i(core_ready_i), .core_v_o(core_v_o), .core_we_o(core_we_o),
      .core_addr_o(core_addr_o), .core_wdata_o(core_wdata_o)
   );

   dram_addr_map i_dram (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i), .sys_reset_n_i(sys_reset_n_o),
      .dram_base_i(dram_base), .dram_v_i(dram_v_i), .dram_addr_i(dram_addr_i),
      .dram_v_o(dram_v_o), .dram_addr_o(dram_addr_o), .prof_o(prof)
   );

   tag_bitbang i_bb (
      .aclk_i(aclk_i), .arst_n_i(arst_n_i), .bb_v_i(bb_v), .bb_bit_i(bb_bit),
      .bb_busy_o(bb_busy), .tag_clk_o(tag_clk_o), .tag_data_o(tag_data_o)
   );

endmodule

//--- sim/tb_checker.sv
`include "shell_macros.svh"

module tb_checker
   import shell_bus_pkg::*;
   import shell_csr_pkg::*;
(
   input logic         aclk_i,
   input logic         arst_n_i,
   input logic         csr_we_i,
   input csr_idx_t     csr_widx_i,
   input data_t        csr_wdata_i,
   input csr_idx_t     csr_ridx_i,
   input data_t        csr_rdata_i,
   input logic         w_req_i,
   input logic         w_we_i,
   input win_addr_t    w_addr_i,
   input data_t        w_wdata_i,
   input logic         w_gnt_i,
   input logic         d_req_i,
   input logic         d_we_i,
   input direct_addr_t d_addr_i,
   input data_t        d_wdata_i,
   input logic         d_gnt_i,
   input logic         core_ready_i,
   input logic         core_v_i,
   input logic         core_we_i,
   input addr_t        core_addr_i,
   input data_t        core_wdata_i,
   input logic         dram_v_i,
   input addr_t        dram_addr_i,
   input logic         dram_v_o_i,
   input addr_t        dram_addr_o_i,
   input logic         sys_reset_n_i,
   input logic         tag_clk_i,
   input logic         tag_data_i
);

   string       test_name = "none";
   int          test_errors = 0;
   int          errors = 0;
   int          tests = 0;
   int          tests_failed = 0;
   int          accepted = 0;

   // reference model of the shell state
   data_t       m_reset;
   data_t       m_bb;
   addr_t       m_base;
   prof_t       m_prof;
   logic        m_strobe;
   int          m_bb_cnt;
   logic        m_tag_bit;
   logic        m_core_v;
   logic        m_prio_d;
   data_t       exp_rdata;
   logic        prev_dram_v;
   addr_t       prev_dram_addr;
   logic [1:0]  exp_gnt;
   logic [64:0] exp_q[$];
   logic [64:0] item;

   ////////////////////////////////////////
   // reference functions

   function automatic addr_t ref_win(win_addr_t a);
      return {~a[29], 3'b000, a[27:0]};
   endfunction

   function automatic addr_t ref_direct(direct_addr_t a);
      return {4'h0, a};
   endfunction

   function automatic addr_t ref_rebase(addr_t a, addr_t base);
      return (a ^ `CORE_DRAM_BASE) + base;
   endfunction

   // bit 1 is the d grant, bit 0 the w grant
   function automatic logic [1:0] ref_grant(logic free, logic wr, logic dr, logic prio_d);
      if (!free) return 2'b00;
      if (wr && dr) return prio_d ? 2'b10 : 2'b01;
      return {dr, wr};
   endfunction

   function automatic data_t ref_read(csr_idx_t idx);
      case (idx)
         3'd0: return m_reset;
         3'd1: return m_bb;
         3'd2: return m_base;
         3'd3: return {31'd0, m_bb_cnt != 0};
         default: return m_prof[(int'(idx) - 4) * 32 +: 32];
      endcase
   endfunction

   ////////////////////////////////////////
   // reporting

   task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         errors++;
         test_errors++;
         $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic report_problem(string msg);
      errors++;
      test_errors++;
      $display("error in %s: %s", test_name, msg);
   endtask

   task automatic begin_test(string name);
      test_name = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests++;
      if (test_errors != 0) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, test_errors);
      end else begin
         $display("test %s: ok", test_name);
      end
   endtask

   task automatic report_counts();
      $display("tests %0d, failed %0d, errors %0d, core transfers %0d",
               tests, tests_failed, errors, accepted);
   endtask

   ////////////////////////////////////////
   // compare on every rising edge, before the DUT flops update
   always @(posedge aclk_i) begin
      if (!arst_n_i) begin
         m_reset = '0;
         m_bb = '0;
         m_base = '0;
         m_prof = '0;
         m_strobe = 1'b0;
         m_bb_cnt = 0;
         m_tag_bit = 1'b0;
         m_core_v = 1'b0;
         m_prio_d = 1'b0;
         exp_rdata = '0;
         prev_dram_v = 1'b0;
         exp_q.delete();
      end else begin
         check_val("sys_reset_n", 32'(m_reset[0]), 32'(sys_reset_n_i));
         check_val("csr_rdata", exp_rdata, csr_rdata_i);
         check_val("dram_v", 32'(prev_dram_v), 32'(dram_v_o_i));
         if (prev_dram_v) begin
            check_val("dram_addr", prev_dram_addr, dram_addr_o_i);
         end
         check_val("tag_clk", 32'(m_bb_cnt == 2), 32'(tag_clk_i));
         if (m_bb_cnt == 2) begin
            check_val("tag_data", 32'(m_tag_bit), 32'(tag_data_i));
         end

         // host ports and core bus
         exp_gnt = ref_grant(!m_core_v || core_ready_i, w_req_i, d_req_i, m_prio_d);
         check_val("w_gnt", 32'(exp_gnt[0]), 32'(w_gnt_i));
         check_val("d_gnt", 32'(exp_gnt[1]), 32'(d_gnt_i));
         check_val("core_v", 32'(m_core_v), 32'(core_v_i));
         if (core_v_i && core_ready_i) begin
            if (exp_q.size() == 0) begin
               report_problem("core bus transfer without a matching grant");
            end else begin
               item = exp_q.pop_front();
               check_val("core_we", 32'(item[64]), 32'(core_we_i));
               check_val("core_addr", item[63:32], core_addr_i);
               check_val("core_wdata", item[31:0], core_wdata_i);
               accepted++;
            end
         end
         if (w_gnt_i) exp_q.push_back({w_we_i, ref_win(w_addr_i), w_wdata_i});
         if (d_gnt_i) exp_q.push_back({d_we_i, ref_direct(d_addr_i), d_wdata_i});

         // advance the model by one cycle
         exp_rdata = ref_read(csr_ridx_i);
         prev_dram_v = dram_v_i;
         prev_dram_addr = ref_rebase(dram_addr_i, m_base);
         if (exp_gnt != 2'b00) begin
            m_core_v = 1'b1;
            m_prio_d = exp_gnt[0];
         end else if (core_ready_i) begin
            m_core_v = 1'b0;
         end
         if (m_bb_cnt != 0) begin
            m_bb_cnt--;
         end else if (m_strobe) begin
            m_bb_cnt = 3;
            m_tag_bit = m_bb[0];
         end
         m_strobe = csr_we_i && (csr_widx_i == 3'd1);
         if (!m_reset[0]) m_prof = '0;
         else if (dram_v_i) m_prof[dram_addr_i[29:23]] = 1'b1;
         if (csr_we_i && csr_widx_i == 3'd0) m_reset = csr_wdata_i;
         if (csr_we_i && csr_widx_i == 3'd1) m_bb = csr_wdata_i;
         if (csr_we_i && csr_widx_i == 3'd2) m_base = csr_wdata_i;
      end
   end

endmodule

//--- sim/tb_top.sv
module tb_top
   import shell_bus_pkg::*;
   import shell_csr_pkg::*;
();

   logic         aclk;
   logic         arst_n;
   logic         csr_we;
   csr_idx_t     csr_widx;
   data_t        csr_wdata;
   csr_idx_t     csr_ridx;
   data_t        csr_rdata;
   logic         w_req;
   logic         w_we;
   win_addr_t    w_addr;
   data_t        w_wdata;
   logic         w_gnt;
   logic         d_req;
   logic         d_we;
   direct_addr_t d_addr;
   data_t        d_wdata;
   logic         d_gnt;
   logic         core_ready;
   logic         core_v;
   logic         core_we;
   addr_t        core_addr;
   data_t        core_wdata;
   logic         dram_v;
   addr_t        dram_addr;
   logic         dram_v_out;
   addr_t        dram_addr_out;
   logic         sys_reset_n;
   logic         tag_clk;
   logic         tag_data;
   logic         w_took;
   logic         d_took;
   logic [31:0]  lfsr_q = 32'h73bf;

   zynq_shell_top i_dut (
      .aclk_i(aclk), .arst_n_i(arst_n),
      .csr_we_i(csr_we), .csr_widx_i(csr_widx), .csr_wdata_i(csr_wdata),
      .csr_ridx_i(csr_ridx), .csr_rdata_o(csr_rdata),
      .w_req_i(w_req), .w_we_i(w_we), .w_addr_i(w_addr), .w_wdata_i(w_wdata),
      .w_gnt_o(w_gnt),
      .d_req_i(d_req), .d_we_i(d_we), .d_addr_i(d_addr), .d_wdata_i(d_wdata),
      .d_gnt_o(d_gnt),
      .core_ready_i(core_ready), .core_v_o(core_v), .core_we_o(core_we),
      .core_addr_o(core_addr), .core_wdata_o(core_wdata),
      .dram_v_i(dram_v), .dram_addr_i(dram_addr), .dram_v_o(dram_v_out),
      .dram_addr_o(dram_addr_out), .sys_reset_n_o(sys_reset_n),
      .tag_clk_o(tag_clk), .tag_data_o(tag_data)
   );

   tb_checker i_chk (
      .aclk_i(aclk), .arst_n_i(arst_n),
      .csr_we_i(csr_we), .csr_widx_i(csr_widx), .csr_wdata_i(csr_wdata),
      .csr_ridx_i(csr_ridx), .csr_rdata_i(csr_rdata),
      .w_req_i(w_req), .w_we_i(w_we), .w_addr_i(w_addr), .w_wdata_i(w_wdata),
      .w_gnt_i(w_gnt),
      .d_req_i(d_req), .d_we_i(d_we), .d_addr_i(d_addr), .d_wdata_i(d_wdata),
      .d_gnt_i(d_gnt),
      .core_ready_i(core_ready), .core_v_i(core_v), .core_we_i(core_we),
      .core_addr_i(core_addr), .core_wdata_i(core_wdata),
      .dram_v_i(dram_v), .dram_addr_i(dram_addr), .dram_v_o_i(dram_v_out),
      .dram_addr_o_i(dram_addr_out), .sys_reset_n_i(sys_reset_n),
      .tag_clk_i(tag_clk), .tag_data_i(tag_data)
   );

   initial begin
      aclk = 1'b0;
      forever #50 aclk = ~aclk;
   end

   // grants seen at the last rising edge
   always @(posedge aclk) begin
      w_took <= w_gnt;
      d_took <= d_gnt;
   end

   ////////////////////////////////////////
   // helpers

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic end_run();
      i_chk.report_counts();
      if (i_chk.errors != 0) begin
         $display(">>> FAIL");
      end else begin
         $display(">>> PASS");
      end
      $finish;
   endtask

   task automatic report_timeout(string what);
      i_chk.report_problem({"timeout while waiting for ", what});
   endtask

   task automatic write_csr(csr_idx_t idx, data_t data);
      @(negedge aclk);
      csr_we = 1'b1;
      csr_widx = idx;
      csr_wdata = data;
      @(negedge aclk);
      csr_we = 1'b0;
   endtask

   // the checker compares every readback against its model
   task automatic read_all();
      for (int i = 0; i < 8; i++) begin
         @(negedge aclk);
         csr_ridx = 3'(i);
      end
      repeat (2) @(negedge aclk);
   endtask

   task automatic wait_tag_pulse();
      int n;
      n = 0;
      while (!tag_clk && n < 20) begin
         @(negedge aclk);
         n++;
      end
      if (n >= 20) report_timeout("a tag clock pulse");
      repeat (4) @(negedge aclk);
   endtask

   task automatic run_requests(int n);
      int w_left;
      int d_left;
      int cyc;
      int start;
      w_left = n;
      d_left = n;
      cyc = 0;
      start = i_chk.accepted;
      while ((w_left > 0 || d_left > 0 || w_req || d_req) && cyc < 2000) begin
         @(negedge aclk);
         cyc++;
         if (w_req && w_took) w_req = 1'b0;
         if (d_req && d_took) d_req = 1'b0;
         if (!w_req && w_left > 0 && rand_bits(1) != 0) begin
            w_req = 1'b1;
            w_we = 1'(rand_bits(1));
            w_addr = 30'(rand_bits(30));
            w_wdata = rand_bits(32);
            w_left--;
         end
         if (!d_req && d_left > 0 && rand_bits(1) != 0) begin
            d_req = 1'b1;
            d_we = 1'(rand_bits(1));
            d_addr = 28'(rand_bits(28));
            d_wdata = rand_bits(32);
            d_left--;
         end
         core_ready = 1'(rand_bits(1));
      end
      if (cyc >= 2000) report_timeout("host port grants");
      // drain whatever is still on the core bus
      core_ready = 1'b1;
      cyc = 0;
      while (i_chk.accepted - start != 2 * n && cyc < 100) begin
         @(negedge aclk);
         cyc++;
      end
      if (cyc >= 100) report_timeout("core bus transfers");
   endtask

   ////////////////////////////////////////
   // stimulus
   initial begin
      arst_n = 1'b0;
      csr_we = 1'b0;
      csr_widx = '0;
      csr_wdata = '0;
      csr_ridx = '0;
      w_req = 1'b0;
      w_we = 1'b0;
      w_addr = '0;
      w_wdata = '0;
      d_req = 1'b0;
      d_we = 1'b0;
      d_addr = '0;
      d_wdata = '0;
      core_ready = 1'b0;
      dram_v = 1'b0;
      dram_addr = '0;
      repeat (2) @(posedge aclk);
      @(negedge aclk);
      arst_n = 1'b1;

      i_chk.begin_test("reset_values");
      read_all();
      i_chk.end_test();

      i_chk.begin_test("csr_readback");
      write_csr(3'd0, rand_bits(32) & 32'hffff_fffe);
      write_csr(3'd2, rand_bits(32));
      write_csr(3'd1, rand_bits(32));
      read_all();
      write_csr(3'd0, rand_bits(32) | 32'h1);
      read_all();
      i_chk.end_test();

      i_chk.begin_test("tag_bitbang");
      // watch the busy flag while the serializer runs
      csr_ridx = 3'd3;
      for (int i = 0; i < 8; i++) begin
         write_csr(3'd1, rand_bits(1));
         wait_tag_pulse();
      end
      // second write lands while the serializer is busy
      write_csr(3'd1, 32'h1);
      write_csr(3'd1, 32'h0);
      wait_tag_pulse();
      repeat (4) @(negedge aclk);
      i_chk.end_test();

      i_chk.begin_test("host_ports");
      run_requests(24);
      i_chk.end_test();

      i_chk.begin_test("dram_rebase");
      write_csr(3'd2, rand_bits(32));
      for (int i = 0; i < 64; i++) begin
         @(negedge aclk);
         dram_v = 1'(rand_bits(1));
         dram_addr = rand_bits(32);
      end
      @(negedge aclk);
      dram_v = 1'b0;
      repeat (2) @(negedge aclk);
      i_chk.end_test();

      i_chk.begin_test("profiler");
      read_all();
      write_csr(3'd0, 32'h0);
      repeat (2) @(negedge aclk);
      read_all();
      i_chk.end_test();

      end_run();
   end

endmodule

//--- src.f
+incdir+include
source/shell_bus_pkg.sv
source/shell_csr_pkg.sv
source/host_csr_regs.sv
source/host_port_arbiter.sv
source/dram_addr_map.sv
source/tag_bitbang.sv
source/zynq_shell_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
   exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
